// File: include/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath width
`define XLEN 32

// physical register number width
`define TAG_W 8

`define MUL_STAGES 3

// ALU results waiting behind the multiplier
`define RESULT_QUEUE_DEPTH 4

`endif

// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // codes 0..12 match the vector file
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SRA   = 4'd7,
        OP_SLT   = 4'd8,
        OP_SLTU  = 4'd9,
        OP_MUL   = 4'd10,
        OP_MULH  = 4'd11,
        OP_MULHU = 4'd12
    } op_e;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

    // which execution unit owns an op
    function automatic unit_e op_unit(input op_e op);
        case (op)
            OP_MUL, OP_MULH, OP_MULHU: return UNIT_MUL;
            default: return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/exec_pkg.sv
`default_nettype none

`include "exec_params.svh"

package exec_pkg;

    // one issued operation, operands already resolved
    typedef struct packed {
        isa_pkg::op_e       op;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`TAG_W-1:0]  tag;   // physical destination
    } issue_t;

    // completion as seen on the forwarding/writeback bus
    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   value;
    } result_t;

endpackage

`default_nettype wire

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module alu_unit (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              issue_valid,
    input  wire exec_pkg::issue_t  issue,
    output logic                   alu_done,
    output exec_pkg::result_t      alu_result
);

    logic             take;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] value;

    assign take  = issue_valid && (isa_pkg::op_unit(issue.op) == isa_pkg::UNIT_ALU);
    assign shamt = issue.b[4:0];   // rv32 shifts use low 5 bits

    always_comb begin
        case (issue.op)
            isa_pkg::OP_ADD:  value = issue.a + issue.b;
            isa_pkg::OP_SUB:  value = issue.a - issue.b;
            isa_pkg::OP_AND:  value = issue.a & issue.b;
            isa_pkg::OP_OR:   value = issue.a | issue.b;
            isa_pkg::OP_XOR:  value = issue.a ^ issue.b;
            isa_pkg::OP_SLL:  value = issue.a << shamt;
            isa_pkg::OP_SRL:  value = issue.a >> shamt;
            isa_pkg::OP_SRA:  value = $signed(issue.a) >>> shamt;
            isa_pkg::OP_SLT: begin
                value = {{(`XLEN-1){1'b0}}, ($signed(issue.a) < $signed(issue.b))};
            end
            isa_pkg::OP_SLTU: begin
                value = {{(`XLEN-1){1'b0}}, (issue.a < issue.b)};
            end
            default:          value = '0;   // mul class, not ours
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= take;
        end
    end

    // payload only moves when an ALU op is taken
    always_ff @(posedge clk) begin
        if (take) begin
            alu_result.tag   <= issue.tag;
            alu_result.value <= value;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module mul_unit (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              issue_valid,
    input  wire exec_pkg::issue_t  issue,
    output logic                   mul_done,
    output exec_pkg::result_t      mul_result
);

    localparam int NS = `MUL_STAGES;

    // per-stage bookkeeping
    typedef struct packed {
        isa_pkg::op_e       op;
        logic [`TAG_W-1:0]  tag;
    } mul_meta_t;

    logic                      take;
    logic                      sgn;
    logic [NS-1:0]             stg_valid;
    mul_meta_t                 stg_meta [NS];
    logic signed [`XLEN:0]     opa;         // 33 bits, sign or zero extended
    logic signed [`XLEN:0]     opb;
    logic signed [2*`XLEN-1:0] prod;
    logic [2*`XLEN-1:0]        stg_prod [1:NS-1];

    assign take = issue_valid && (isa_pkg::op_unit(issue.op) == isa_pkg::UNIT_MUL);
    assign sgn  = (issue.op == isa_pkg::OP_MULH);
    assign prod = opa * opb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else begin
            stg_valid <= {stg_valid[NS-2:0], take};
        end
    end

    always_ff @(posedge clk) begin
        // stage 0 latches operands
        stg_meta[0] <= '{op: issue.op, tag: issue.tag};
        opa         <= {sgn & issue.a[`XLEN-1], issue.a};
        opb         <= {sgn & issue.b[`XLEN-1], issue.b};
        stg_prod[1] <= prod;
        for (int i = 1; i < NS; i++) begin
            stg_meta[i] <= stg_meta[i-1];
        end
        for (int i = 2; i < NS; i++) begin
            stg_prod[i] <= stg_prod[i-1];
        end
    end

    assign mul_done       = stg_valid[NS-1];
    assign mul_result.tag = stg_meta[NS-1].tag;

    // low half for MUL, high half for MULH/MULHU
    assign mul_result.value = (stg_meta[NS-1].op == isa_pkg::OP_MUL)
                            ? stg_prod[NS-1][`XLEN-1:0]
                            : stg_prod[NS-1][2*`XLEN-1:`XLEN];

endmodule

`default_nettype wire

// File: hdl/writeback_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module writeback_arbiter (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               alu_done,
    input  wire exec_pkg::result_t  alu_result,
    input  wire logic               mul_done,
    input  wire exec_pkg::result_t  mul_result,
    output logic                    result_valid,
    output exec_pkg::result_t       result
);

    localparam int QD    = `RESULT_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(QD);

    exec_pkg::result_t queue_mem [QD];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [PTR_W:0]    count;
    logic              q_empty;
    logic              push;
    logic              pop;

    assign q_empty = (count == '0);
    // ALU result parks if it loses to mul or would overtake older entries
    assign push    = alu_done && (mul_done || !q_empty);
    assign pop     = !mul_done && !q_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(QD-1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(QD-1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[tail] <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mul_done || alu_done || !q_empty;
        end
    end

    // mul first, then oldest queued, then a fresh ALU result
    always_ff @(posedge clk) begin
        if (mul_done) begin
            result <= mul_result;
        end else if (!q_empty) begin
            result <= queue_mem[head];
        end else if (alu_done) begin
            result <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              issue_valid,
    input  wire exec_pkg::issue_t  issue,
    output wire logic              result_valid,
    output wire exec_pkg::result_t result
);

    wire logic              alu_done;
    wire exec_pkg::result_t alu_result;
    wire logic              mul_done;
    wire exec_pkg::result_t mul_result;

    // both units see every issue and filter by class
    alu_unit u_alu_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_done    (alu_done),
        .alu_result  (alu_result)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .mul_done    (mul_done),
        .mul_result  (mul_result)
    );

    writeback_arbiter u_writeback_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_done     (alu_done),
        .alu_result   (alu_result),
        .mul_done     (mul_done),
        .mul_result   (mul_result),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: testbench/tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_params.svh"

module tb_exec_cluster;

    localparam int MAX_VEC = 64;

    logic              clk;
    logic              rst_n;
    logic              issue_valid;
    exec_pkg::issue_t  issue;
    logic              result_valid;
    exec_pkg::result_t result;

    logic [3:0]        vec_op     [MAX_VEC];
    logic [`XLEN-1:0]  vec_a      [MAX_VEC];
    logic [`XLEN-1:0]  vec_b      [MAX_VEC];
    logic [`XLEN-1:0]  vec_exp    [MAX_VEC];
    bit                seen       [MAX_VEC];
    bit                isolated   [MAX_VEC];   // issued into an empty pipeline
    int                issue_edge [MAX_VEC];
    int                nvec;
    int                issued_count;
    int                seen_count;
    int                cycle_count;
    int                last_alu_tag;
    int                iso_alu;
    int                iso_mul;
    int unsigned       lcg_state;
    bit                loaded;

    exec_cluster uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result)
    );

    always #4 clk = ~clk;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bit is_mul(input logic [3:0] code);
        return isa_pkg::op_unit(isa_pkg::op_e'(code)) == isa_pkg::UNIT_MUL;
    endfunction

    // rv32i and M-extension result rules, by opcode code
    function automatic logic [`XLEN-1:0] ref_value(input logic [3:0] code,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
        logic signed [2*`XLEN-1:0] sp;
        logic [2*`XLEN-1:0]        up;
        sp = $signed({{`XLEN{a[`XLEN-1]}}, a}) * $signed({{`XLEN{b[`XLEN-1]}}, b});
        up = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (code)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[4:0];
            4'd6:    return a >> b[4:0];
            4'd7:    return $signed(a) >>> b[4:0];
            4'd8:    return ($signed(a) < $signed(b)) ? 1 : 0;
            4'd9:    return (a < b) ? 1 : 0;
            4'd10:   return up[`XLEN-1:0];
            4'd11:   return sp[2*`XLEN-1:`XLEN];
            4'd12:   return up[2*`XLEN-1:`XLEN];
            default: return 'x;   // not a valid opcode
        endcase
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input string name, input exec_pkg::result_t got,
                                input exec_pkg::result_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got tag %0d value %h, expected tag %0d value %h",
                     $time, name, got.tag, got.value, exp.tag, exp.value);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL t=%0t %s: got %0d cycles, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [3:0]       code;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] e;
        fd = $fopen("testbench/exec_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/exec_vectors.txt");
            abort_run();
        end
        nvec = 0;
        n = $fscanf(fd, "%h %h %h %h\n", code, a, b, e);
        while (n == 4 && nvec < MAX_VEC) begin
            if (e !== ref_value(code, a, b)) begin
                $display("vector %0d disagrees with the rule for opcode %0d", nvec, code);
                abort_run();
            end
            vec_op[nvec]  = code;
            vec_a[nvec]   = a;
            vec_b[nvec]   = b;
            vec_exp[nvec] = e;
            nvec++;
            n = $fscanf(fd, "%h %h %h %h\n", code, a, b, e);
        end
        $fclose(fd);
        if (nvec < 2) begin
            $display("vector file holds fewer than two operations");
            abort_run();
        end
    endtask

    task automatic issue_op(input int idx);
        @(negedge clk);
        isolated[idx]   = (issued_count == seen_count);
        issue_edge[idx] = cycle_count + 1;   // edge that samples this issue
        issue_valid     = 1'b1;
        issue.op        = isa_pkg::op_e'(vec_op[idx]);
        issue.a         = vec_a[idx];
        issue.b         = vec_b[idx];
        issue.tag       = `TAG_W'(idx);
        issued_count++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (seen_count != issued_count) @(negedge clk);
    endtask

    task automatic take_result(input exec_pkg::result_t r);
        int                t;
        exec_pkg::result_t exp;
        t = int'(r.tag);
        if (t >= issued_count) begin
            $display("result bus carried tag %0d, which was never issued", t);
            abort_run();
        end
        if (seen[t]) begin
            $display("tag %0d appeared on the result bus a second time", t);
            abort_run();
        end
        seen[t] = 1'b1;
        seen_count++;
        exp.tag   = `TAG_W'(t);
        exp.value = vec_exp[t];
        check_result("result", r, exp);
        if (isolated[t] && is_mul(vec_op[t])) begin
            check_latency("result_valid latency", cycle_count - issue_edge[t], `MUL_STAGES + 1);
            iso_mul++;
        end else if (isolated[t]) begin
            check_latency("result_valid latency", cycle_count - issue_edge[t], 2);
            iso_alu++;
        end
        if (!is_mul(vec_op[t])) begin
            check_flag("alu result order", t > last_alu_tag, 1'b1);
            last_alu_tag = t;
        end
    endtask

    // scoreboard on values settled before this edge
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (rst_n === 1'b1) begin
            if (issued_count == seen_count) begin
                check_flag("result_valid", result_valid, 1'b0);
            end else if (result_valid === 1'b1) begin
                take_result(result);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (nvec * 3 + `MUL_STAGES + 20) @(posedge clk);
        $display("watchdog expired with %0d of %0d results seen, results are missing",
                 seen_count, nvec);
        abort_run();
    end

    initial begin
        int unsigned gap;
        clk          = 1'b0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        issued_count = 0;
        seen_count   = 0;
        cycle_count  = 0;
        last_alu_tag = -1;
        iso_alu      = 0;
        iso_mul      = 0;
        lcg_state    = 32'd68009;
        for (int i = 0; i < MAX_VEC; i++) begin
            seen[i]     = 1'b0;
            isolated[i] = 1'b0;
        end
        load_vectors();
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) idle_cycle();   // bus must stay quiet
        issue_op(0);
        idle_cycle();
        wait_drained();
        issue_op(1);
        idle_cycle();
        wait_drained();
        for (int i = 2; i < nvec; i++) begin
            issue_op(i);
            lcg_state = lcg_next(lcg_state);
            gap = (lcg_state >> 16) % 3;
            repeat (gap) idle_cycle();
        end
        idle_cycle();
        wait_drained();
        repeat (4) idle_cycle();
        if (iso_alu > 0 && iso_mul > 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("no isolated ALU and multiplier issue took place, latency unchecked");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hdl/isa_pkg.sv
hdl/exec_pkg.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/writeback_arbiter.sv
hdl/exec_cluster.sv
testbench/tb_exec_cluster.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_exec_cluster
FILELIST  = all.f
OBJDIR    = obj_dir

BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv testbench/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJDIR)

// File: testbench/exec_vectors.txt
0 00000005 00000003 00000008
a 00000007 00000006 0000002a
1 00000003 00000005 fffffffe
0 ffffffff 00000001 00000000
b ffffffff ffffffff 00000000
2 f0f0f0f0 ff00ff00 f000f000
3 f0f0f0f0 0f0f0f0f ffffffff
4 12345678 ffffffff edcba987
c ffffffff ffffffff fffffffe
5 00000001 0000001f 80000000
6 80000000 0000001f 00000001
7 80000000 0000001f ffffffff
a 80000000 80000000 00000000
8 ffffffff 00000001 00000001
9 ffffffff 00000001 00000000
b 80000000 80000000 40000000
5 00000003 00000024 00000030
7 f0000000 00000004 ff000000
c 80000000 80000000 40000000
0 7fffffff 00000001 80000000
1 80000000 00000001 7fffffff
a ffffffff 00000002 fffffffe
b ffffffff 00000002 ffffffff
c ffffffff 00000002 00000001
8 7fffffff 80000000 00000000
9 7fffffff 80000000 00000001
4 aaaaaaaa 55555555 ffffffff
2 12345678 0000ffff 00005678
a 12345678 00000010 23456780
b 80000000 00000001 ffffffff
6 f0000000 00000004 0f000000
7 70000000 00000004 07000000
c 00010000 00010000 00000001
3 00000000 00000000 00000000
8 80000000 7fffffff 00000001
a 0000ffff 0000ffff fffe0001
0 deadbeef 00000000 deadbeef
b 7fffffff 7fffffff 3fffffff
